/* sensor_pkg.sv */
package sensor_pkg;

    // Raw Bayer sample as delivered by the sensor
    typedef logic [9:0] pixel_t;

    // Top eight bits of a sample, as stored and metered
    typedef logic [7:0] pixel_byte_t;

    // Position counters within a frame
    typedef logic [10:0] coord_x_t;
    typedef logic [9:0]  coord_y_t;

    // Byte address into the frame buffer
    typedef logic [15:0] buffer_addr_t;

    // Sensor stream, one pixel per clock while line_valid is high
    typedef struct packed {
        logic   frame_valid;
        logic   line_valid;
        pixel_t data;
    } pixel_stream_t;

    // Per-channel means of the metering window
    typedef struct packed {
        pixel_byte_t red;
        pixel_byte_t green;
        pixel_byte_t blue;
    } meter_result_t;

endpackage

/* command_pkg.sv */
package command_pkg;

    // Command op-codes
    typedef enum logic [7:0] {
        OP_CAPTURE = 8'h20,
        OP_READ    = 8'h22,
        OP_METER   = 8'h25
    } opcode_e;

    // Byte returned to the host
    typedef logic [7:0] response_t;

    // Operand count of a metering command
    // 0 red, 1 green, 2 blue
    typedef logic [1:0] meter_index_t;

    // One-frame capture sequence
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARMED,
        CAP_ACTIVE
    } capture_state_e;

endpackage

/* frame_crop.sv */
module frame_crop #(
    parameter sensor_pkg::coord_x_t X_CROP_START = 2,
    parameter sensor_pkg::coord_x_t X_CROP_END   = 10,
    parameter sensor_pkg::coord_y_t Y_CROP_START = 2,
    parameter sensor_pkg::coord_y_t Y_CROP_END   = 8
) (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  sensor_pkg::pixel_stream_t stream_i,
    output sensor_pkg::pixel_stream_t stream_o
);
    import sensor_pkg::*;

    coord_x_t x_count;
    coord_y_t y_count;
    logic     line_valid_q;
    logic     in_window;
    logic     frame_valid_out;
    logic     line_valid_out;
    pixel_t   data_out;

    // Position of the pixel now at the input, half-open window
    assign in_window = (x_count >= X_CROP_START) && (x_count < X_CROP_END) &&
                       (y_count >= Y_CROP_START) && (y_count < Y_CROP_END);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count      <= '0;
            y_count      <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= stream_i.line_valid;

            // Column restarts on every line
            if (stream_i.line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
            end

            // Row steps at each line end, restarts between frames
            if (!stream_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_q && !stream_i.line_valid) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_out <= 1'b0;
            line_valid_out  <= 1'b0;
        end else begin
            frame_valid_out <= stream_i.frame_valid;
            line_valid_out  <= stream_i.line_valid && in_window;
        end
    end

    always_ff @(posedge clock_spi_in) begin
        data_out <= stream_i.data;
    end

    assign stream_o = '{frame_valid: frame_valid_out, line_valid: line_valid_out, data: data_out};

    // Window must be non-empty in both directions
    assert property (@(posedge clock_spi_in)
        (X_CROP_START < X_CROP_END) && (Y_CROP_START < Y_CROP_END));

endmodule

/* exposure_metering.sv */
module exposure_metering #(
    parameter sensor_pkg::coord_x_t METER_X_START = 4,
    parameter sensor_pkg::coord_y_t METER_Y_START = 2,
    parameter int                   METER_LOG2_W  = 3,
    parameter int                   METER_LOG2_H  = 2
) (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  sensor_pkg::pixel_stream_t stream_i,
    output sensor_pkg::meter_result_t meter_o
);
    import sensor_pkg::*;

    localparam int SUM_W    = $bits(pixel_byte_t) + METER_LOG2_W + METER_LOG2_H;
    // Red and blue hold a quarter of the window sites, green half
    localparam int RB_SHIFT = METER_LOG2_W + METER_LOG2_H - 2;
    localparam int G_SHIFT  = METER_LOG2_W + METER_LOG2_H - 1;
    localparam int X_END    = METER_X_START + (1 << METER_LOG2_W);
    localparam int Y_END    = METER_Y_START + (1 << METER_LOG2_H);

    pixel_stream_t    stream_q;
    logic             frame_valid_qq;
    logic             line_valid_qq;
    coord_x_t         x_count;
    coord_y_t         y_count;
    logic             in_window;
    logic             red_site;
    logic             blue_site;
    logic             frame_end;
    pixel_byte_t      sample;
    logic [SUM_W-1:0] red_sum;
    logic [SUM_W-1:0] green_sum;
    logic [SUM_W-1:0] blue_sum;

    assign sample    = stream_q.data[$bits(pixel_t)-1 -: $bits(pixel_byte_t)];
    assign frame_end = frame_valid_qq && !stream_q.frame_valid;
    assign in_window = stream_q.line_valid &&
                       (x_count >= METER_X_START) && (x_count < X_END) &&
                       (y_count >= METER_Y_START) && (y_count < Y_END);

    // RGGB mosaic
    assign red_site  = !y_count[0] && !x_count[0];
    assign blue_site = y_count[0] && x_count[0];

    // Input stage plus position counters on the registered stream
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            stream_q       <= '0;
            frame_valid_qq <= 1'b0;
            line_valid_qq  <= 1'b0;
            x_count        <= '0;
            y_count        <= '0;
        end else begin
            stream_q       <= stream_i;
            frame_valid_qq <= stream_q.frame_valid;
            line_valid_qq  <= stream_q.line_valid;
            x_count        <= stream_q.line_valid ? x_count + 1'b1 : '0;
            if (!stream_q.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_qq && !stream_q.line_valid) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
            meter_o   <= '0;
        end else if (frame_end) begin
            // Means are powers of two, so a plain shift
            meter_o.red   <= pixel_byte_t'(red_sum >> RB_SHIFT);
            meter_o.green <= pixel_byte_t'(green_sum >> G_SHIFT);
            meter_o.blue  <= pixel_byte_t'(blue_sum >> RB_SHIFT);
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
        end else if (in_window) begin
            if (red_site) begin
                red_sum <= red_sum + SUM_W'(sample);
            end else if (blue_site) begin
                blue_sum <= blue_sum + SUM_W'(sample);
            end else begin
                green_sum <= green_sum + SUM_W'(sample);
            end
        end
    end

endmodule

/* capture_control.sv */
module capture_control (
    input  logic clock_spi_in,
    input  logic mipi_byte_reset_n,
    input  logic capture_request_i,
    input  logic frame_valid_i,
    output logic capture_active_o
);
    import command_pkg::*;

    capture_state_e state;
    logic           request_pending;
    logic           request_seen;

    assign request_seen = capture_request_i || request_pending;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state           <= CAP_IDLE;
            request_pending <= 1'b0;
        end else begin
            case (state)
                CAP_IDLE: begin
                    // Only arm in the gap between frames
                    if (request_seen && !frame_valid_i) begin
                        state <= CAP_ARMED;
                    end
                end
                CAP_ARMED: begin
                    if (frame_valid_i) begin
                        state <= CAP_ACTIVE;
                    end
                end
                CAP_ACTIVE: begin
                    if (!frame_valid_i) begin
                        state <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase

            // Request seen mid-frame waits here for the next gap
            if (state == CAP_IDLE && !frame_valid_i) begin
                request_pending <= 1'b0;
            end else if (capture_request_i) begin
                request_pending <= 1'b1;
            end
        end
    end

    assign capture_active_o = (state == CAP_ACTIVE);

    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        state inside {CAP_IDLE, CAP_ARMED, CAP_ACTIVE});

endmodule

/* frame_buffer.sv */
module frame_buffer #(
    parameter int BUFFER_DEPTH = 64
) (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  sensor_pkg::pixel_stream_t stream_i,
    input  logic                      capture_active_i,
    input  sensor_pkg::buffer_addr_t  read_addr_i,
    output sensor_pkg::pixel_byte_t   read_data_o
);
    import sensor_pkg::*;

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);

    pixel_byte_t  mem [BUFFER_DEPTH];
    buffer_addr_t write_addr;
    buffer_addr_t write_addr_eff;
    logic         capture_active_q;
    logic         capture_start;
    logic         write_en;
    pixel_byte_t  write_byte;

    assign capture_start = capture_active_i && !capture_active_q;
    assign write_en      = capture_active_i && stream_i.frame_valid && stream_i.line_valid;
    assign write_byte    = stream_i.data[$bits(pixel_t)-1 -: $bits(pixel_byte_t)];

    // A new capture fills from address zero
    assign write_addr_eff = capture_start ? '0 : write_addr;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            capture_active_q <= 1'b0;
            write_addr       <= '0;
        end else begin
            capture_active_q <= capture_active_i;
            if (write_en) begin
                write_addr <= write_addr_eff + 1'b1;
            end else begin
                write_addr <= write_addr_eff;
            end
        end
    end

    // Byte RAM, one write and one registered read per cycle
    always_ff @(posedge clock_spi_in) begin
        if (write_en) begin
            mem[write_addr_eff[ADDR_W-1:0]] <= write_byte;
        end
        read_data_o <= mem[read_addr_i[ADDR_W-1:0]];
    end

    // Crop window has to fit the buffer
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        write_en |-> (write_addr_eff < BUFFER_DEPTH));

endmodule

/* command_decoder.sv */
module command_decoder (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  command_pkg::opcode_e      op_code_i,
    input  logic                      op_code_valid_i,
    input  logic                      operand_valid_i,
    input  command_pkg::meter_index_t operand_count_i,
    input  sensor_pkg::meter_result_t meter_i,
    input  sensor_pkg::pixel_byte_t   read_data_i,
    output sensor_pkg::buffer_addr_t  read_addr_o,
    output logic                      capture_request_o,
    output command_pkg::response_t    response_o,
    output logic                      response_valid_o
);
    import command_pkg::*;

    logic op_code_valid_q;
    logic operand_valid_q;
    logic operand_rise;

    assign operand_rise = operand_valid_i && !operand_valid_q;

    // One pulse on the first cycle of a capture command
    assign capture_request_o = op_code_valid_i && !op_code_valid_q &&
                               (op_code_i == OP_CAPTURE);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            op_code_valid_q  <= 1'b0;
            operand_valid_q  <= 1'b0;
            read_addr_o      <= '0;
            response_o       <= '0;
            response_valid_o <= 1'b0;
        end else begin
            op_code_valid_q <= op_code_valid_i;
            operand_valid_q <= operand_valid_i;

            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_CAPTURE: begin
                        read_addr_o      <= '0;
                        response_valid_o <= 1'b0;
                    end
                    OP_READ: begin
                        // Buffer byte for the address set last cycle
                        response_o       <= read_data_i;
                        response_valid_o <= 1'b1;
                        if (operand_rise) begin
                            read_addr_o <= read_addr_o + 1'b1;
                        end
                    end
                    OP_METER: begin
                        response_valid_o <= 1'b1;
                        case (operand_count_i)
                            2'd0:    response_o <= meter_i.red;
                            2'd1:    response_o <= meter_i.green;
                            2'd2:    response_o <= meter_i.blue;
                            default: response_o <= '0;
                        endcase
                    end
                    default: response_valid_o <= 1'b0;
                endcase
            end else begin
                response_valid_o <= 1'b0;
            end
        end
    end

    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        response_valid_o |-> $past(op_code_valid_i));

endmodule

/* camera.sv */
module camera #(
    parameter sensor_pkg::coord_x_t X_CROP_START  = 2,
    parameter sensor_pkg::coord_x_t X_CROP_END    = 10,
    parameter sensor_pkg::coord_y_t Y_CROP_START  = 2,
    parameter sensor_pkg::coord_y_t Y_CROP_END    = 8,
    parameter sensor_pkg::coord_x_t METER_X_START = 4,
    parameter sensor_pkg::coord_y_t METER_Y_START = 2,
    parameter int                   METER_LOG2_W  = 3,
    parameter int                   METER_LOG2_H  = 2,
    parameter int                   BUFFER_DEPTH  = 64
) (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  sensor_pkg::pixel_stream_t pixel_stream_i,
    input  command_pkg::opcode_e      op_code_i,
    input  logic                      op_code_valid_i,
    input  logic                      operand_valid_i,
    input  command_pkg::meter_index_t operand_count_i,
    output command_pkg::response_t    response_o,
    output logic                      response_valid_o
);
    import sensor_pkg::*;

    pixel_stream_t cropped_stream;
    meter_result_t meter;
    buffer_addr_t  read_addr;
    pixel_byte_t   read_data;
    logic          capture_request;
    logic          capture_active;

    frame_crop #(
        .X_CROP_START(X_CROP_START),
        .X_CROP_END  (X_CROP_END),
        .Y_CROP_START(Y_CROP_START),
        .Y_CROP_END  (Y_CROP_END)
    ) frame_crop_i (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .stream_i         (pixel_stream_i),
        .stream_o         (cropped_stream)
    );

    // Metering sees the full uncropped frame
    exposure_metering #(
        .METER_X_START(METER_X_START),
        .METER_Y_START(METER_Y_START),
        .METER_LOG2_W (METER_LOG2_W),
        .METER_LOG2_H (METER_LOG2_H)
    ) exposure_metering_i (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .stream_i         (pixel_stream_i),
        .meter_o          (meter)
    );

    capture_control capture_control_i (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .capture_request_i(capture_request),
        .frame_valid_i    (cropped_stream.frame_valid),
        .capture_active_o (capture_active)
    );

    frame_buffer #(
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) frame_buffer_i (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .stream_i         (cropped_stream),
        .capture_active_i (capture_active),
        .read_addr_i      (read_addr),
        .read_data_o      (read_data)
    );

    command_decoder command_decoder_i (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .op_code_i        (op_code_i),
        .op_code_valid_i  (op_code_valid_i),
        .operand_valid_i  (operand_valid_i),
        .operand_count_i  (operand_count_i),
        .meter_i          (meter),
        .read_data_i      (read_data),
        .read_addr_o      (read_addr),
        .capture_request_o(capture_request),
        .response_o       (response_o),
        .response_valid_o (response_valid_o)
    );

endmodule

/* tb_checker.sv */
module tb_checker #(
    parameter int X_CROP_START  = 2,
    parameter int X_CROP_END    = 10,
    parameter int Y_CROP_START  = 2,
    parameter int Y_CROP_END    = 8,
    parameter int METER_X_START = 4,
    parameter int METER_Y_START = 2,
    parameter int METER_LOG2_W  = 3,
    parameter int METER_LOG2_H  = 2,
    parameter int BUFFER_DEPTH  = 64
) (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  sensor_pkg::pixel_stream_t pixel_stream_i,
    input  command_pkg::opcode_e      op_code_i,
    input  logic                      op_code_valid_i,
    input  logic                      operand_valid_i,
    input  command_pkg::meter_index_t operand_count_i,
    input  command_pkg::response_t    response_i,
    input  logic                      response_valid_i,
    output int                        error_count_o,
    output int                        check_count_o,
    output int                        valid_error_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import sensor_pkg::*;
    import command_pkg::*;

    localparam int METER_X_END = METER_X_START + (1 << METER_LOG2_W);
    localparam int METER_Y_END = METER_Y_START + (1 << METER_LOG2_H);

    pixel_byte_t  model_mem [BUFFER_DEPTH];
    pixel_byte_t  means [3];
    int           sums [3];
    int           sites [3];
    int           col;
    int           row;
    int           write_addr;
    int           read_addr;
    int           read_addr_q1;
    int           read_addr_q2;
    logic         capture_pending;
    logic         capturing;
    logic         frame_valid_q;
    logic         line_valid_q;
    logic         operand_valid_q;
    logic         op_valid_q;
    opcode_e      op_q;
    meter_index_t count_q;
    int           errors = 0;
    int           checks = 0;
    int           valid_errors = 0;

    assign error_count_o       = errors;
    assign check_count_o       = checks;
    assign valid_error_count_o = valid_errors;

    // RGGB: 0 red, 1 green, 2 blue
    function automatic int site_channel(input int x, input int y);
        if ((y % 2 == 0) && (x % 2 == 0)) begin
            return 0;
        end
        if ((y % 2 == 1) && (x % 2 == 1)) begin
            return 2;
        end
        return 1;
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reset_model();
        for (int ch = 0; ch < 3; ch++) begin
            means[ch] = '0;
            sums[ch]  = 0;
            sites[ch] = 0;
        end
        capture_pending = 1'b0;
        capturing       = 1'b0;
        read_addr       = 0;
        read_addr_q1    = 0;
        read_addr_q2    = 0;
        frame_valid_q   = 1'b0;
        line_valid_q    = 1'b0;
        operand_valid_q = 1'b0;
        op_valid_q      = 1'b0;
        op_q            = OP_CAPTURE;
        count_q         = '0;
    endtask

    // Response of this cycle against the command of the cycle before
    task automatic check_response();
        logic expect_valid;
        expect_valid = op_valid_q && (op_q == OP_READ || op_q == OP_METER);
        checks++;
        if (response_valid_i !== expect_valid) begin
            errors++;
            valid_errors++;
            $display("Fail time=%0t signal=response_valid_o expected=%b actual=%b",
                     $time, expect_valid, response_valid_i);
        end
        if (op_valid_q && op_q == OP_METER) begin
            compare_byte("response_o", (count_q < 3) ? means[count_q] : 8'h00, response_i);
        end else if (op_valid_q && op_q == OP_READ) begin
            // Address register, then RAM read, then response register
            compare_byte("response_o", model_mem[read_addr_q2], response_i);
        end
    endtask

    task automatic track_command();
        int next_addr;
        next_addr = read_addr;
        if (op_code_valid_i && op_code_i == OP_CAPTURE) begin
            capture_pending = 1'b1;
            next_addr       = 0;
        end else if (op_code_valid_i && op_code_i == OP_READ &&
                     operand_valid_i && !operand_valid_q) begin
            next_addr = read_addr + 1;
        end
        read_addr_q2    = read_addr_q1;
        read_addr_q1    = read_addr;
        read_addr       = next_addr;
        operand_valid_q = operand_valid_i;
        op_valid_q      = op_code_valid_i;
        op_q            = op_code_i;
        count_q         = operand_count_i;
    endtask

    task automatic track_stream();
        pixel_stream_t s;
        int            ch;
        s = pixel_stream_i;
        if (s.frame_valid && !frame_valid_q) begin
            col = 0;
            row = 0;
            for (int i = 0; i < 3; i++) begin
                sums[i]  = 0;
                sites[i] = 0;
            end
            // Only a request seen before the frame starts captures it
            if (capture_pending) begin
                capturing       = 1'b1;
                capture_pending = 1'b0;
                write_addr      = 0;
            end
        end
        if (s.frame_valid && s.line_valid) begin
            if (col >= METER_X_START && col < METER_X_END &&
                row >= METER_Y_START && row < METER_Y_END) begin
                ch = site_channel(col, row);
                sums[ch]  += int'(s.data[9:2]);
                sites[ch] += 1;
            end
            if (capturing && col >= X_CROP_START && col < X_CROP_END &&
                row >= Y_CROP_START && row < Y_CROP_END) begin
                model_mem[write_addr] = s.data[9:2];
                write_addr++;
            end
            col++;
        end else begin
            col = 0;
            if (s.frame_valid && line_valid_q) begin
                row++;
            end
        end
        if (!s.frame_valid && frame_valid_q) begin
            for (int i = 0; i < 3; i++) begin
                means[i] = (sites[i] > 0) ? pixel_byte_t'(sums[i] / sites[i]) : '0;
            end
            capturing = 1'b0;
        end
        frame_valid_q = s.frame_valid;
        line_valid_q  = s.line_valid;
    endtask

    always @(posedge clock_spi_in) begin
        if (!mipi_byte_reset_n) begin
            reset_model();
        end else begin
            check_response();
            track_command();
            track_stream();
        end
    end

endmodule

/* tb_camera.sv */
module tb_camera;
    timeunit 1ns;
    timeprecision 1ps;

    import sensor_pkg::*;
    import command_pkg::*;

    localparam int CLOCK_PERIOD  = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int COLS          = 16;
    localparam int ROWS          = 12;
    localparam int FRAME_LEAD    = 2;
    localparam int LINE_GAP      = 4;
    localparam int FRAME_GAP     = 8;
    localparam int X_CROP_START  = 2;
    localparam int X_CROP_END    = 10;
    localparam int Y_CROP_START  = 2;
    localparam int Y_CROP_END    = 8;
    localparam int METER_X_START = 4;
    localparam int METER_Y_START = 2;
    localparam int METER_LOG2_W  = 3;
    localparam int METER_LOG2_H  = 2;
    localparam int BUFFER_DEPTH  = 64;

    localparam int CROP_BYTES     = (X_CROP_END - X_CROP_START) * (Y_CROP_END - Y_CROP_START);
    localparam int FRAME_CYCLES   = FRAME_LEAD + ROWS * (COLS + LINE_GAP) + FRAME_GAP;
    localparam int READ_CYCLES    = 2 * CROP_BYTES + 6;
    // Three reads, three captures, one metering command
    localparam int COMMAND_CYCLES = 3 * READ_CYCLES + 3 * 4 + 8;
    localparam int TIMEOUT_CYCLES =
        (RESET_CYCLES + 6 * FRAME_CYCLES + COMMAND_CYCLES) * 12 / 10;

    logic          clock_spi_in;
    logic          mipi_byte_reset_n;
    pixel_stream_t pixel_stream;
    opcode_e       op_code;
    logic          op_code_valid;
    logic          operand_valid;
    meter_index_t  operand_count;
    response_t     response;
    logic          response_valid;
    int            error_count;
    int            check_count;
    int            valid_error_count;
    int            error_mark;
    int            check_mark;
    int            tests_run;
    int            cycle_count;
    logic [31:0]   rng_state;

    camera #(
        .X_CROP_START (X_CROP_START),
        .X_CROP_END   (X_CROP_END),
        .Y_CROP_START (Y_CROP_START),
        .Y_CROP_END   (Y_CROP_END),
        .METER_X_START(METER_X_START),
        .METER_Y_START(METER_Y_START),
        .METER_LOG2_W (METER_LOG2_W),
        .METER_LOG2_H (METER_LOG2_H),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) dut_i (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_stream_i   (pixel_stream),
        .op_code_i        (op_code),
        .op_code_valid_i  (op_code_valid),
        .operand_valid_i  (operand_valid),
        .operand_count_i  (operand_count),
        .response_o       (response),
        .response_valid_o (response_valid)
    );

    tb_checker #(
        .X_CROP_START (X_CROP_START),
        .X_CROP_END   (X_CROP_END),
        .Y_CROP_START (Y_CROP_START),
        .Y_CROP_END   (Y_CROP_END),
        .METER_X_START(METER_X_START),
        .METER_Y_START(METER_Y_START),
        .METER_LOG2_W (METER_LOG2_W),
        .METER_LOG2_H (METER_LOG2_H),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) checker_i (
        .clock_spi_in       (clock_spi_in),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .pixel_stream_i     (pixel_stream),
        .op_code_i          (op_code),
        .op_code_valid_i    (op_code_valid),
        .operand_valid_i    (operand_valid),
        .operand_count_i    (operand_count),
        .response_i         (response),
        .response_valid_i   (response_valid),
        .error_count_o      (error_count),
        .check_count_o      (check_count),
        .valid_error_count_o(valid_error_count)
    );

    initial begin
        clock_spi_in = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock_spi_in = ~clock_spi_in;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One clock cycle of sensor stream
    task automatic drive_stream(input logic fv, input logic lv, input pixel_t data);
        @(posedge clock_spi_in);
        pixel_stream <= '{frame_valid: fv, line_valid: lv, data: data};
    endtask

    // One clock cycle of command inputs
    task automatic drive_command(input logic valid, input opcode_e op,
                                 input logic operand, input meter_index_t count);
        @(posedge clock_spi_in);
        op_code_valid <= valid;
        op_code       <= op;
        operand_valid <= operand;
        operand_count <= count;
    endtask

    task automatic stream_frame();
        int row;
        int col;
        repeat (FRAME_LEAD) drive_stream(1'b1, 1'b0, '0);
        for (row = 0; row < ROWS; row++) begin
            for (col = 0; col < COLS; col++) begin
                rng_state = xorshift32(rng_state);
                drive_stream(1'b1, 1'b1, pixel_t'(rng_state));
            end
            repeat (LINE_GAP) drive_stream(1'b1, 1'b0, '0);
        end
        repeat (FRAME_GAP) drive_stream(1'b0, 1'b0, '0);
    endtask

    task automatic send_capture();
        repeat (2) drive_command(1'b1, OP_CAPTURE, 1'b0, '0);
        repeat (2) drive_command(1'b0, OP_CAPTURE, 1'b0, '0);
    endtask

    // Red, green, blue, two cycles each
    task automatic send_meter();
        int index;
        for (index = 0; index < 3; index++) begin
            repeat (2) drive_command(1'b1, OP_METER, 1'b1, meter_index_t'(index));
        end
        repeat (2) drive_command(1'b0, OP_METER, 1'b0, '0);
    endtask

    task automatic read_buffer(input int count);
        int index;
        repeat (2) drive_command(1'b1, OP_READ, 1'b0, '0);
        for (index = 1; index < count; index++) begin
            drive_command(1'b1, OP_READ, 1'b1, '0);
            drive_command(1'b1, OP_READ, 1'b0, '0);
        end
        // Let the last address reach the response register
        repeat (2) drive_command(1'b1, OP_READ, 1'b0, '0);
        repeat (2) drive_command(1'b0, OP_READ, 1'b0, '0);
    endtask

    task automatic report_test(input string name);
        @(negedge clock_spi_in);
        tests_run++;
        $display("%s: %0d checks, %0d errors", name,
                 check_count - check_mark, error_count - error_mark);
        check_mark = check_count;
        error_mark = error_count;
    endtask

    initial begin
        rng_state         = 32'h3f03c8dd;
        mipi_byte_reset_n = 1'b0;
        pixel_stream      = '0;
        op_code           = OP_READ;
        op_code_valid     = 1'b0;
        operand_valid     = 1'b0;
        operand_count     = '0;
        error_mark        = 0;
        check_mark        = 0;
        tests_run         = 0;
        repeat (RESET_CYCLES) @(posedge clock_spi_in);
        mipi_byte_reset_n <= 1'b1;

        stream_frame();
        report_test("test 1 no response after reset");

        stream_frame();
        send_meter();
        report_test("test 2 metering means");

        send_capture();
        stream_frame();
        read_buffer(CROP_BYTES);
        report_test("test 3 capture between frames");

        // Request lands halfway through a frame
        fork
            stream_frame();
            begin
                repeat (FRAME_CYCLES / 2) @(posedge clock_spi_in);
                send_capture();
            end
        join
        stream_frame();
        read_buffer(CROP_BYTES);
        report_test("test 4 capture during a frame");

        send_capture();
        stream_frame();
        read_buffer(16);
        report_test("test 5 second capture restarts reads");

        tests_run++;
        $display("test 6 response_valid timing: %0d mismatches over the run",
                 valid_error_count);

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock_spi_in);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
        $display("Test failed");
        $finish;
    end

endmodule

/* sim.f */
sensor_pkg.sv
command_pkg.sv
frame_crop.sv
exposure_metering.sv
capture_control.sv
frame_buffer.sv
command_decoder.sv
camera.sv
tb_checker.sv
tb_camera.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_camera
FILE_LIST  := sim.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
